//--- Makefile
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= pipelineTb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/pipelineTb.sv
module pipelineTb import cpuPkg::*; ();

    localparam int IMEM_ADDR_W  = 6;
    localparam int DMEM_ADDR_W  = 6;
    localparam int DMEM_DEPTH   = 2**DMEM_ADDR_W;
    localparam int CLK_PERIOD   = 20;
    localparam int N_BODY       = 40;             // instructions before halt
    localparam int PROG_LEN     = N_BODY + 1;
    localparam int WATCH_CYCLES = 8 + PROG_LEN + 4 + 10 * PROG_LEN;

    typedef logic [DMEM_ADDR_W-1:0] memAddrT;

    logic    clk = 1'b0;
    logic    i_arstN;
    logic    i_run;
    logic    i_loadWe;
    wordT    i_loadData;
    logic    o_wbWe;
    regAddrT o_wbReg;
    wordT    o_wbData;
    logic    o_memWe;
    memAddrT o_memAddr;
    wordT    o_memData;
    logic    o_end;

    logic [31:0] rngState = 32'h3c7d_2208;
    wordT        progMem [PROG_LEN];
    int          progLen;
    wordT        modelRegs [2**REG_ADDR_W];
    wordT        modelMem [DMEM_DEPTH];
    bit          stored [DMEM_DEPTH];
    int          storedWords [$];   // words a load may safely read
    regAddrT     expWrReg [$];
    wordT        expWrData [$];
    memAddrT     expStAddr [$];
    wordT        expStData [$];
    logic        endSeen;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pipelineTop #(
        .IMEM_ADDR_W (IMEM_ADDR_W),
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) uut (
        .clk        (clk       ),
        .i_arstN    (i_arstN   ),
        .i_run      (i_run     ),
        .i_loadWe   (i_loadWe  ),
        .i_loadData (i_loadData),
        .o_wbWe     (o_wbWe    ),
        .o_wbReg    (o_wbReg   ),
        .o_wbData   (o_wbData  ),
        .o_memWe    (o_memWe   ),
        .o_memAddr  (o_memAddr ),
        .o_memData  (o_memData ),
        .o_end      (o_end     )
    );

    // -------------------------------------------------------------------------
    // random source and encoders
    // -------------------------------------------------------------------------
    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    function automatic int randBelow(int n);
        logic [31:0] r;
        r = nextRand();
        return int'(r[31:16]) % n;  // upper bits are the better ones
    endfunction

    function automatic regAddrT randReg();
        return regAddrT'(randBelow(7) + 1);  // r1..r7, many hazards
    endfunction

    function automatic wordT encodeR(functT fn, regAddrT rd, regAddrT rs, regAddrT rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT encodeI(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // -------------------------------------------------------------------------
    // instruction-set model, one instruction at a time in program order
    // -------------------------------------------------------------------------
    task automatic writeModelReg(input regAddrT dst, input wordT value);
        if (dst != '0) begin
            modelRegs[dst] = value;
            expWrReg.push_back(dst);
            expWrData.push_back(value);
        end
    endtask

    task automatic modelExecute(input wordT instr);
        wordT    a, b, imm, res, addr;
        int      word;
        regAddrT rs, rt, rd;
        rs   = instr[25:21];
        rt   = instr[20:16];
        rd   = instr[15:11];
        imm  = {{16{instr[15]}}, instr[15:0]};
        a    = modelRegs[rs];
        b    = modelRegs[rt];
        addr = a + imm;
        word = int'(addr[31:2]) % DMEM_DEPTH;  // byte address to word index
        case (instr[31:26])
            OP_RTYPE: begin
                case (instr[5:0])
                    FN_ADD:  res = a + b;
                    FN_SUB:  res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: res = '0;
                endcase
                writeModelReg(rd, res);
            end
            OP_ADDI: writeModelReg(rt, addr);
            OP_LW:   writeModelReg(rt, modelMem[word]);
            OP_SW: begin
                modelMem[word] = b;
                expStAddr.push_back(memAddrT'(word));
                expStData.push_back(b);
                if (!stored[word]) begin
                    stored[word] = 1'b1;
                    storedWords.push_back(word);
                end
            end
            default: ;  // halt
        endcase
    endtask

    task automatic appendInstr(input wordT instr);
        progMem[progLen] = instr;
        progLen++;
        modelExecute(instr);
    endtask

    task automatic buildProgram();
        regAddrT rs, rt, rd;
        int      kind;
        int      k;
        int      w;
        wordT    instr;
        progLen = 0;
        foreach (modelRegs[i]) modelRegs[i] = '0;
        foreach (stored[i]) stored[i] = 1'b0;
        // give r1..r7 a defined value first
        for (int r = 1; r < 8; r++) begin
            appendInstr(encodeI(OP_ADDI, '0, regAddrT'(r), 16'(nextRand())));
        end
        for (int i = 7; i < N_BODY; i++) begin
            rs   = randReg();
            rt   = randReg();
            rd   = randReg();
            kind = randBelow(10);
            if ((kind == 6 || kind == 7) && storedWords.size() == 0) begin
                kind = 8;  // nothing to load yet
            end
            case (kind)
                0: instr = encodeR(FN_ADD, rd, rs, rt);
                1: instr = encodeR(FN_SUB, rd, rs, rt);
                2: instr = encodeR(FN_AND, rd, rs, rt);
                3: instr = encodeR(FN_OR, rd, rs, rt);
                4: instr = encodeR(FN_SLT, rd, rs, rt);
                5: instr = encodeI(OP_ADDI, rs, rt, 16'(nextRand()));
                6, 7: begin
                    // offset chosen so the load lands on a stored word
                    w     = storedWords[randBelow(storedWords.size())];
                    k     = (w - int'(modelRegs[rs][DMEM_ADDR_W+1:2]) + DMEM_DEPTH) % DMEM_DEPTH;
                    instr = encodeI(OP_LW, rs, rt, 16'(4 * k));
                end
                default: instr = encodeI(OP_SW, rs, rt, 16'(4 * randBelow(16)));
            endcase
            appendInstr(instr);
        end
        appendInstr({OP_HALT, 26'd0});
    endtask

    // -------------------------------------------------------------------------
    // checks
    // -------------------------------------------------------------------------
    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkWrite(input regAddrT gotReg, input wordT gotData);
        regAddrT expReg;
        wordT    expData;
        if (expWrReg.size() == 0) begin
            stopOnError("register write seen after the last expected one");
        end else begin
            expReg  = expWrReg.pop_front();
            expData = expWrData.pop_front();
            if (gotReg !== expReg) begin
                stopOnError($sformatf("[FAIL] o_wbReg: got 0x%h, expected 0x%h",
                                      gotReg, expReg));
            end else if (gotData !== expData) begin
                stopOnError($sformatf("[FAIL] o_wbData: got 0x%h, expected 0x%h",
                                      gotData, expData));
            end
        end
    endtask

    task automatic checkStore(input memAddrT gotAddr, input wordT gotData);
        memAddrT expAddr;
        wordT    expData;
        if (expStAddr.size() == 0) begin
            stopOnError("store seen after the last expected one");
        end else begin
            expAddr = expStAddr.pop_front();
            expData = expStData.pop_front();
            if (gotAddr !== expAddr) begin
                stopOnError($sformatf("[FAIL] o_memAddr: got 0x%h, expected 0x%h",
                                      gotAddr, expAddr));
            end else if (gotData !== expData) begin
                stopOnError($sformatf("[FAIL] o_memData: got 0x%h, expected 0x%h",
                                      gotData, expData));
            end
        end
    endtask

    task automatic expectIdle(input string phase);
        if (o_wbWe !== 1'b0 || o_memWe !== 1'b0) begin
            stopOnError({"register write or store seen ", phase});
        end
    endtask

    // -------------------------------------------------------------------------
    // main sequence
    // -------------------------------------------------------------------------
    initial begin
        i_arstN    = 1'b0;
        i_run      = 1'b0;
        i_loadWe   = 1'b0;
        i_loadData = '0;
        endSeen    = 1'b0;
        buildProgram();
        repeat (8) @(posedge clk);
        i_arstN <= 1'b1;

        for (int i = 0; i < progLen; i++) begin
            @(posedge clk);
            i_loadWe   <= 1'b1;
            i_loadData <= progMem[i];
            @(negedge clk);
            expectIdle("during program load");
            if (o_end !== 1'b0) begin
                stopOnError("o_end high during program load");
            end
        end
        @(posedge clk);
        i_loadWe <= 1'b0;
        @(posedge clk);
        i_run <= 1'b1;  // loader is off one cycle before the run

        while (!endSeen) begin
            @(negedge clk);
            if (o_wbWe) begin
                checkWrite(o_wbReg, o_wbData);
            end
            if (o_memWe) begin
                checkStore(o_memAddr, o_memData);
            end
            if (o_end) begin
                if (expWrReg.size() != 0 || expStAddr.size() != 0) begin
                    stopOnError("o_end rose before all expected writes and stores");
                end
                endSeen = 1'b1;
            end
        end

        // pipeline must stay quiet after halt retires
        repeat (8) begin
            @(negedge clk);
            expectIdle("after o_end");
            if (o_end !== 1'b1) begin
                stopOnError("o_end dropped after rising");
            end
        end

        $display("Testbench passed");
        $finish;
    end

    initial begin
        #(WATCH_CYCLES * CLK_PERIOD);
        stopOnError("timeout, the core did not reach the end of the program in time");
    end

endmodule

//--- hdl/cpuPkg.sv
package cpuPkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [DATA_W-1:0]     wordT;
    typedef logic [REG_ADDR_W-1:0] regAddrT;

    // -------------------------------------------------------------------------
    // instruction fields
    // -------------------------------------------------------------------------
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B,
        OP_HALT  = 6'h3F
    } opcodeT;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } functT;

    // -------------------------------------------------------------------------
    // datapath controls
    // -------------------------------------------------------------------------
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOpT;

    typedef enum logic [1:0] {
        FWD_NONE,  // value read in decode
        FWD_EXMEM,
        FWD_MEMWB
    } fwdSelT;

endpackage

//--- hdl/decodeStage.sv
module decodeStage import cpuPkg::*; (
    input  logic    clk       ,
    input  logic    i_arstN   ,
    input  wordT    i_instr   ,
    input  logic    i_valid   ,
    input  logic    i_wbWe    ,
    input  regAddrT i_wbReg   ,
    input  wordT    i_wbData  ,
    output logic    o_stall   ,
    output logic    o_halted  ,
    output wordT    o_opA     ,
    output wordT    o_opB     ,
    output wordT    o_imm     ,
    output regAddrT o_rs      ,
    output regAddrT o_rt      ,
    output regAddrT o_dst     ,
    output aluOpT   o_aluOp   ,
    output logic    o_useImm  ,
    output logic    o_memRead ,
    output logic    o_memWrite,
    output logic    o_regWrite,
    output logic    o_halt
);

    wordT    regFile [2**REG_ADDR_W];
    opcodeT  opcode;
    functT   funct;
    regAddrT rs, rt, rd, dst;
    aluOpT   aluOp;
    logic    useImm, memRead, memWrite, regWrite, isHalt;
    logic    instrLive;  // valid and not past halt
    logic    advance;
    wordT    readA, readB;

    assign opcode = opcodeT'(i_instr[31:26]);
    assign funct  = functT'(i_instr[5:0]);
    assign rs     = i_instr[25:21];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];

    // -------------------------------------------------------------------------
    // control decode
    // -------------------------------------------------------------------------
    always_comb begin
        aluOp    = ALU_ADD;
        useImm   = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b0;
        isHalt   = 1'b0;
        dst      = rd;
        case (opcode)
            OP_RTYPE: begin
                regWrite = 1'b1;
                case (funct)
                    FN_ADD:  aluOp = ALU_ADD;
                    FN_SUB:  aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_SLT:  aluOp = ALU_SLT;
                    default: regWrite = 1'b0;  // unknown funct runs as a nop
                endcase
            end
            OP_ADDI: begin
                useImm   = 1'b1;
                regWrite = 1'b1;
                dst      = rt;
            end
            OP_LW: begin
                useImm   = 1'b1;
                memRead  = 1'b1;
                regWrite = 1'b1;
                dst      = rt;
            end
            OP_SW: begin
                useImm   = 1'b1;
                memWrite = 1'b1;
            end
            OP_HALT: isHalt = 1'b1;
            default: ;
        endcase
    end

    // register file, write-back passes straight through to the read
    function automatic wordT rfRead(regAddrT idx);
        if (idx == '0) begin
            return '0;
        end else if (i_wbWe && (i_wbReg == idx)) begin
            return i_wbData;
        end
        return regFile[idx];
    endfunction

    assign readA = rfRead(rs);
    assign readB = rfRead(rt);

    always_ff @(posedge clk) begin
        if (i_wbWe && (i_wbReg != '0)) begin
            regFile[i_wbReg] <= i_wbData;
        end
    end

    // load in EX feeding this instruction -> one bubble
    assign instrLive = i_valid && !o_halted;
    assign o_stall   = instrLive && o_memRead && ((o_dst == rs) || (o_dst == rt));
    assign advance   = instrLive && !o_stall;

    // -------------------------------------------------------------------------
    // ID/EX register
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_memRead  <= 1'b0;
            o_memWrite <= 1'b0;
            o_regWrite <= 1'b0;
            o_halt     <= 1'b0;
            o_halted   <= 1'b0;
        end else begin
            o_memRead  <= advance && memRead;
            o_memWrite <= advance && memWrite;
            o_regWrite <= advance && regWrite && (dst != '0);  // r0 never written
            o_halt     <= advance && isHalt;
            if (advance && isHalt) begin
                o_halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        o_opA    <= readA;
        o_opB    <= readB;
        o_imm    <= {{(DATA_W-16){i_instr[15]}}, i_instr[15:0]};  // sign extend
        o_rs     <= rs;
        o_rt     <= rt;
        o_dst    <= dst;
        o_aluOp  <= aluOp;
        o_useImm <= useImm;
    end

    assert property (@(posedge clk) disable iff (!i_arstN) i_wbWe |-> (i_wbReg != '0))
        else $error("write-back to register 0");

endmodule

//--- hdl/executeStage.sv
module executeStage import cpuPkg::*; (
    input  logic    clk        ,
    input  logic    i_arstN    ,
    input  wordT    i_opA      ,
    input  wordT    i_opB      ,
    input  wordT    i_imm      ,
    input  regAddrT i_rs       ,
    input  regAddrT i_rt       ,
    input  regAddrT i_dst      ,
    input  aluOpT   i_aluOp    ,
    input  logic    i_useImm   ,
    input  logic    i_memRead  ,
    input  logic    i_memWrite ,
    input  logic    i_regWrite ,
    input  logic    i_halt     ,
    input  logic    i_wbWe     ,
    input  regAddrT i_wbReg    ,
    input  wordT    i_wbData   ,
    output wordT    o_result   ,
    output wordT    o_storeData,
    output regAddrT o_dst      ,
    output logic    o_memRead  ,
    output logic    o_memWrite ,
    output logic    o_regWrite ,
    output logic    o_halt
);

    fwdSelT fwdA, fwdB;
    wordT   srcA, srcB;   // operands after forwarding
    wordT   aluB;
    wordT   aluOut;

    // -------------------------------------------------------------------------
    // forwarding
    // -------------------------------------------------------------------------
    function automatic fwdSelT fwdPick(regAddrT src);
        if ((src != '0) && o_regWrite && (o_dst == src)) begin
            return FWD_EXMEM;  // youngest result wins
        end else if ((src != '0) && i_wbWe && (i_wbReg == src)) begin
            return FWD_MEMWB;
        end
        return FWD_NONE;
    endfunction

    function automatic wordT fwdMux(fwdSelT sel, wordT regVal);
        case (sel)
            FWD_EXMEM: return o_result;
            FWD_MEMWB: return i_wbData;
            default:   return regVal;
        endcase
    endfunction

    assign fwdA = fwdPick(i_rs);
    assign fwdB = fwdPick(i_rt);
    assign srcA = fwdMux(fwdA, i_opA);
    assign srcB = fwdMux(fwdB, i_opB);
    assign aluB = i_useImm ? i_imm : srcB;

    always_comb begin
        case (i_aluOp)
            ALU_SUB: aluOut = srcA - aluB;
            ALU_AND: aluOut = srcA & aluB;
            ALU_OR:  aluOut = srcA | aluB;
            ALU_SLT: aluOut = ($signed(srcA) < $signed(aluB)) ? wordT'(1) : '0;
            default: aluOut = srcA + aluB;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_memRead  <= 1'b0;
            o_memWrite <= 1'b0;
            o_regWrite <= 1'b0;
            o_halt     <= 1'b0;
        end else begin
            o_memRead  <= i_memRead;
            o_memWrite <= i_memWrite;
            o_regWrite <= i_regWrite;
            o_halt     <= i_halt;
        end
    end

    always_ff @(posedge clk) begin
        o_result    <= aluOut;
        o_storeData <= srcB;  // sw data is rt, forwarded
        o_dst       <= i_dst;
    end

    assert property (@(posedge clk) disable iff (!i_arstN) !(i_memRead && i_memWrite))
        else $error("load and store flagged on one instruction");

endmodule

//--- hdl/fetchStage.sv
module fetchStage import cpuPkg::*; #(
    parameter int IMEM_ADDR_W = 6
) (
    input  logic clk       ,
    input  logic i_arstN   ,
    input  logic i_run     ,
    input  logic i_loadWe  ,
    input  wordT i_loadData,
    input  logic i_stall   ,
    input  logic i_halted  ,
    output wordT o_instr   ,
    output logic o_valid
);

    wordT                   imem [2**IMEM_ADDR_W];
    logic [IMEM_ADDR_W-1:0] pc;
    logic [IMEM_ADDR_W-1:0] loadPtr;  // next word to be loaded
    logic                   loadWr;
    logic                   fetchEn;

    assign loadWr  = i_loadWe && !i_run;
    assign fetchEn = i_run && !i_stall && !i_halted;

    // program load port
    always_ff @(posedge clk) begin
        if (loadWr) begin
            imem[loadPtr] <= i_loadData;
        end
    end

    always_ff @(posedge clk or negedge i_arstN) begin
        if (!i_arstN) begin
            pc      <= '0;
            loadPtr <= '0;
            o_valid <= 1'b0;
        end else begin
            if (loadWr) begin
                loadPtr <= loadPtr + 1'b1;
            end
            if (!i_run || i_halted) begin
                o_valid <= 1'b0;     // nothing fetched past halt
            end else if (!i_stall) begin
                pc      <= pc + 1'b1;
                o_valid <= 1'b1;
            end
        end
    end

    // IF/ID instruction, held on stall
    always_ff @(posedge clk) begin
        if (fetchEn) begin
            o_instr <= imem[pc];
        end
    end

    // loader must be done before the core starts
    assert property (@(posedge clk) disable iff (!i_arstN) i_run |-> !i_loadWe)
        else $error("program load write while running");

endmodule

//--- hdl/memoryStage.sv
module memoryStage import cpuPkg::*; #(
    parameter int DMEM_ADDR_W = 6
) (
    input  logic                   clk        ,
    input  logic                   i_arstN    ,
    input  wordT                   i_result   ,
    input  wordT                   i_storeData,
    input  regAddrT                i_dst      ,
    input  logic                   i_memRead  ,
    input  logic                   i_memWrite ,
    input  logic                   i_regWrite ,
    input  logic                   i_halt     ,
    output logic                   o_wbWe     ,
    output regAddrT                o_wbReg    ,
    output wordT                   o_wbData   ,
    output logic                   o_memWe    ,
    output logic [DMEM_ADDR_W-1:0] o_memAddr  ,
    output wordT                   o_memData  ,
    output logic                   o_end
);

    wordT                   dmem [2**DMEM_ADDR_W];
    logic [DMEM_ADDR_W-1:0] wordAddr;
    wordT                   loadQ;       // MEM/WB copy of memory data
    wordT                   aluQ;
    logic                   memToRegQ;

    assign wordAddr = i_result[DMEM_ADDR_W+1:2];  // byte address to word index

    always_ff @(posedge clk) begin
        if (i_memWrite) begin
            dmem[wordAddr] <= i_storeData;
        end
    end

    // store port seen from outside
    assign o_memWe   = i_memWrite;
    assign o_memAddr = wordAddr;
    assign o_memData = i_storeData;

    // -------------------------------------------------------------------------
    // MEM/WB register
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_wbWe    <= 1'b0;
            memToRegQ <= 1'b0;
            o_end     <= 1'b0;
        end else begin
            o_wbWe    <= i_regWrite;
            memToRegQ <= i_memRead;
            if (i_halt) begin
                o_end <= 1'b1;  // sticky once halt retires
            end
        end
    end

    always_ff @(posedge clk) begin
        loadQ   <= dmem[wordAddr];
        aluQ    <= i_result;
        o_wbReg <= i_dst;
    end

    assign o_wbData = memToRegQ ? loadQ : aluQ;  // write-back select

endmodule

//--- hdl/pipelineTop.sv
module pipelineTop import cpuPkg::*; #(
    parameter int IMEM_ADDR_W = 6,
    parameter int DMEM_ADDR_W = 6
) (
    input  logic                   clk       ,
    input  logic                   i_arstN   ,
    input  logic                   i_run     ,
    input  logic                   i_loadWe  ,
    input  wordT                   i_loadData,
    output logic                   o_wbWe    ,
    output regAddrT                o_wbReg   ,
    output wordT                   o_wbData  ,
    output logic                   o_memWe   ,
    output logic [DMEM_ADDR_W-1:0] o_memAddr ,
    output wordT                   o_memData ,
    output logic                   o_end
);

    // IF -> ID
    wordT    ifInstr;
    logic    ifValid;
    logic    idStall, idHalted;

    // ID -> EX
    wordT    idOpA, idOpB, idImm;
    regAddrT idRs, idRt, idDst;
    aluOpT   idAluOp;
    logic    idUseImm, idMemRead, idMemWrite, idRegWrite, idHalt;

    // EX -> MEM
    wordT    exResult, exStoreData;
    regAddrT exDst;
    logic    exMemRead, exMemWrite, exRegWrite, exHalt;

    // -------------------------------------------------------------------------
    // stages
    // -------------------------------------------------------------------------
    fetchStage #(
        .IMEM_ADDR_W (IMEM_ADDR_W)
    ) ifInst (
        .clk        (clk       ),
        .i_arstN    (i_arstN   ),
        .i_run      (i_run     ),
        .i_loadWe   (i_loadWe  ),
        .i_loadData (i_loadData),
        .i_stall    (idStall   ),
        .i_halted   (idHalted  ),
        .o_instr    (ifInstr   ),
        .o_valid    (ifValid   )
    );

    decodeStage idInst (
        .clk        (clk       ),
        .i_arstN    (i_arstN   ),
        .i_instr    (ifInstr   ),
        .i_valid    (ifValid   ),
        .i_wbWe     (o_wbWe    ),  // write-back loops to the register file
        .i_wbReg    (o_wbReg   ),
        .i_wbData   (o_wbData  ),
        .o_stall    (idStall   ),
        .o_halted   (idHalted  ),
        .o_opA      (idOpA     ),
        .o_opB      (idOpB     ),
        .o_imm      (idImm     ),
        .o_rs       (idRs      ),
        .o_rt       (idRt      ),
        .o_dst      (idDst     ),
        .o_aluOp    (idAluOp   ),
        .o_useImm   (idUseImm  ),
        .o_memRead  (idMemRead ),
        .o_memWrite (idMemWrite),
        .o_regWrite (idRegWrite),
        .o_halt     (idHalt    )
    );

    executeStage exInst (
        .clk         (clk        ),
        .i_arstN     (i_arstN    ),
        .i_opA       (idOpA      ),
        .i_opB       (idOpB      ),
        .i_imm       (idImm      ),
        .i_rs        (idRs       ),
        .i_rt        (idRt       ),
        .i_dst       (idDst      ),
        .i_aluOp     (idAluOp    ),
        .i_useImm    (idUseImm   ),
        .i_memRead   (idMemRead  ),
        .i_memWrite  (idMemWrite ),
        .i_regWrite  (idRegWrite ),
        .i_halt      (idHalt     ),
        .i_wbWe      (o_wbWe     ),  // MEM/WB forwarding source
        .i_wbReg     (o_wbReg    ),
        .i_wbData    (o_wbData   ),
        .o_result    (exResult   ),
        .o_storeData (exStoreData),
        .o_dst       (exDst      ),
        .o_memRead   (exMemRead  ),
        .o_memWrite  (exMemWrite ),
        .o_regWrite  (exRegWrite ),
        .o_halt      (exHalt     )
    );

    memoryStage #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) memInst (
        .clk         (clk        ),
        .i_arstN     (i_arstN    ),
        .i_result    (exResult   ),
        .i_storeData (exStoreData),
        .i_dst       (exDst      ),
        .i_memRead   (exMemRead  ),
        .i_memWrite  (exMemWrite ),
        .i_regWrite  (exRegWrite ),
        .i_halt      (exHalt     ),
        .o_wbWe      (o_wbWe     ),
        .o_wbReg     (o_wbReg    ),
        .o_wbData    (o_wbData   ),
        .o_memWe     (o_memWe    ),
        .o_memAddr   (o_memAddr  ),
        .o_memData   (o_memData  ),
        .o_end       (o_end      )
    );

endmodule

//--- sim.f
hdl/cpuPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/pipelineTop.sv
bench/pipelineTb.sv
